// ==== Makefile ====
# Verilator build and run of the display front end testbench
VERILATOR ?= verilator
TOP       ?= mpg_display_tb
FILELIST  ?= mpg_display_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Test failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/mpg_display_tb_model.svh ====
`ifndef MPG_DISPLAY_TB_MODEL_SVH
`define MPG_DISPLAY_TB_MODEL_SVH

// ======================================================================
// Reference model holding the state left by the last clock edge
// ======================================================================

int              m_div;
int              m_h;
int              m_v;
logic            m_hs;
logic            m_vs;
logic            m_de;
logic            m_vs_prev;
int              m_edges;
logic            m_active;
logic            m_mnt_prev;
logic [63:0]     m_fsize;
logic [HB_W-1:0] m_hb;
logic [1:0]      m_disk;

int checks = 0;
int errors = 0;

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("ERROR %0t %s got %0h expected %0h", $time, name, got, exp);
    end
endtask

task automatic model_reset();
    m_div      = 0;
    m_h        = 0;
    m_v        = 0;
    {m_hs, m_vs, m_de} = 3'b000;
    m_vs_prev  = 1'b0;
    m_edges    = 0;
    m_active   = 1'b0;
    m_mnt_prev = 1'b0;
    m_fsize    = '0;
    m_hb       = '0;
    m_disk     = 2'b00;
endtask

// Expected outputs for the current cycle and inputs
task automatic check_outputs();
    check_value("ce_pixel", 64'(ce_pixel), 64'(m_div == 0));
    check_value("vga_r", 64'(vga_r), 64'(m_active ? core_r : WHITE));
    check_value("vga_g", 64'(vga_g), 64'(m_active ? core_g : WHITE));
    check_value("vga_b", 64'(vga_b), 64'(m_active ? core_b : WHITE));
    check_value("vga_hs", 64'(vga_hs), 64'(m_active ? core_hsync : m_hs));
    check_value("vga_vs", 64'(vga_vs), 64'(m_active ? core_vsync : m_vs));
    check_value("vga_de", 64'(vga_de), 64'(m_active ? core_de : m_de));
    check_value("stream_start", 64'(stream_start), 64'(img_mounted && !m_mnt_prev));
    check_value("file_size", file_size, m_fsize);
    check_value("core_video_active", 64'(core_video_active), 64'(m_active));
    check_value("led_user", 64'(led_user), 64'(m_hb[HB_W-1]));
    check_value("led_disk", 64'(led_disk), 64'(m_disk));
endtask

// Next state from current state and inputs
task automatic model_advance();
    if (m_div == 0) begin
        // Syncs from the position before the step
        m_hs = (m_h >= H_SS) && (m_h <= H_SE);
        m_vs = (m_v >= V_SS) && (m_v <= V_SE);
        m_de = (m_h < H_ACT) && (m_v < V_ACT);
        if (m_h == H_TOT - 1) begin
            m_h = 0;
            m_v = (m_v == V_TOT - 1) ? 0 : m_v + 1;
        end else begin
            m_h = m_h + 1;
        end
    end
    m_div = (m_div + 1) % 4;
    // Edge counted only before the switch
    if (core_vsync && !m_vs_prev && !m_active) begin
        m_edges = m_edges + 1;
        if (m_edges == LOCK) begin
            m_active = 1'b1;
        end
    end
    m_vs_prev  = core_vsync;
    m_mnt_prev = img_mounted;
    if (img_mounted) begin
        m_fsize = img_size;
    end
    m_hb   = m_hb + 1'b1;
    m_disk = {stream_active, stream_valid};
endtask

`endif

// ==== dv/mpg_display_tb.sv ====
module mpg_display_tb;

    // Small raster so a frame takes a few hundred clocks
    localparam int H_TOT = 16;
    localparam int H_ACT = 10;
    localparam int H_SS  = 12;
    localparam int H_SE  = 13;
    localparam int V_TOT = 8;
    localparam int V_ACT = 5;
    localparam int V_SS  = 6;
    localparam int V_SE  = 6;
    localparam int LOCK  = 3;
    localparam int HB_W  = 5;
    localparam logic [7:0] WHITE = 8'hff;

    logic clk_sys = 1'b0;
    logic reset_n;
    // Decoder video into the DUT
    logic [7:0] core_r;
    logic [7:0] core_g;
    logic [7:0] core_b;
    logic core_hsync;
    logic core_vsync;
    logic core_de;
    // Host and streamer side
    logic img_mounted;
    logic stream_active;
    logic stream_valid;
    logic [63:0] img_size;
    // DUT outputs
    logic [7:0] vga_r;
    logic [7:0] vga_g;
    logic [7:0] vga_b;
    logic vga_hs;
    logic vga_vs;
    logic vga_de;
    logic ce_pixel;
    logic stream_start;
    logic core_video_active;
    logic led_user;
    logic [63:0] file_size;
    logic [1:0] led_disk;
    integer seed = 32'h75ca7aa1;
    int gap;
    int n;
    int e0;

    `include "mpg_display_tb_model.svh"

    always #2 clk_sys = ~clk_sys;

    mpg_display_top #(
        .H_ACTIVE (H_ACT), .H_SYNC_START (H_SS), .H_SYNC_END (H_SE), .H_TOTAL (H_TOT),
        .V_ACTIVE (V_ACT), .V_SYNC_START (V_SS), .V_SYNC_END (V_SE), .V_TOTAL (V_TOT),
        .LOCK_EDGES (LOCK), .HEARTBEAT_W (HB_W)
    ) uut (.*);

    // Drive on the rising edge and check on the falling edge
    task automatic step(input bit vs_on, input bit side_on);
        @(posedge clk_sys);
        core_r     <= 8'($random(seed));
        core_g     <= 8'($random(seed));
        core_b     <= 8'($random(seed));
        core_hsync <= $random(seed) % 2 != 0;
        core_de    <= $random(seed) % 2 != 0;
        core_vsync <= vs_on && ($random(seed) % 6 == 0);
        if (side_on) begin
            img_mounted   <= $random(seed) % 3 != 0;
            img_size      <= {$random(seed), $random(seed)};
            stream_active <= $random(seed) % 2 != 0;
            stream_valid  <= $random(seed) % 2 != 0;
        end
        @(negedge clk_sys);
        check_outputs();
        model_advance();
    endtask

    // Count clocks until led_user changes, up to a bound
    task automatic measure_led_period(output int cycles);
        logic last;
        int k;
        last = led_user;
        k = 0;
        while (led_user == last && k < 64) begin
            step(1'b1, 1'b1);
            k++;
        end
        if (led_user == last) begin
            errors++;
            $display("Timeout: led_user did not toggle within 64 clocks");
        end
        cycles = k;
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%s finished with %0d errors", name, errors - err_before);
    endtask

    initial begin
        reset_n = 1'b0;
        {core_r, core_g, core_b, core_hsync, core_vsync, core_de} = '0;
        {img_mounted, img_size, stream_active, stream_valid} = '0;
        model_reset();
        repeat (2) @(posedge clk_sys);
        reset_n <= 1'b1;

        // ==================================================================
        // Reset state and first pixel enable
        // ==================================================================
        e0 = errors;
        @(negedge clk_sys);
        check_value("ce_pixel", 64'(ce_pixel), 64'd1);
        check_value("vga_hs", 64'(vga_hs), 64'd0);
        check_value("vga_vs", 64'(vga_vs), 64'd0);
        check_value("vga_de", 64'(vga_de), 64'd0);
        check_value("stream_start", 64'(stream_start), 64'd0);
        check_value("core_video_active", 64'(core_video_active), 64'd0);
        check_value("led_disk", 64'(led_disk), 64'd0);
        check_outputs();
        model_advance();
        report_test("reset", e0);

        // Three fallback frames with the decoder vsync held low
        e0 = errors;
        repeat (3 * H_TOT * V_TOT * 4) step(1'b0, 1'b0);
        report_test("fallback raster", e0);

        // Decoder vsync pulses until the switch and decoder pass-through after it
        e0 = errors;
        n = 0;
        while (!core_video_active && n < 500) begin
            step(1'b1, 1'b0);
            n++;
        end
        if (!core_video_active) begin
            errors++;
            $display("Timeout: decoder video was never selected");
        end
        repeat (200) step(1'b1, 1'b0);
        report_test("decoder switch", e0);

        // ==================================================================
        // Mount tracking, heartbeat and disk LEDs
        // ==================================================================
        e0 = errors;
        repeat (300) step(1'b1, 1'b1);
        report_test("image mount", e0);

        // First call only lines up with a toggle
        e0 = errors;
        measure_led_period(gap);
        measure_led_period(gap);
        check_value("led_user period", 64'(gap), 64'd16);
        report_test("heartbeat", e0);

        e0 = errors;
        repeat (300) step(1'b1, 1'b1);
        report_test("disk leds", e0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== mpg_display_top.f ====
+incdir+dv
src/mpg_display_pkg.sv
src/video_frame_timer.sv
src/video_source_select.sv
src/image_mount_tracker.sv
src/status_led.sv
src/mpg_display_top.sv
dv/mpg_display_tb.sv

// ==== src/image_mount_tracker.sv ====
module image_mount_tracker (
    input  logic                        clk_sys,
    input  logic                        reset_n,
    input  logic                        img_mounted,
    input  mpg_display_pkg::file_size_t img_size,
    output logic                        stream_start,
    output mpg_display_pkg::file_size_t file_size
);

    logic mounted_prev;

    // ======================================================================
    // Mount edge and size latch
    // ======================================================================

    // New mount seen this cycle
    assign stream_start = img_mounted && !mounted_prev;

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            mounted_prev <= 1'b0;
            file_size    <= '0;
        end else begin
            mounted_prev <= img_mounted;
            // Size follows the host for as long as the mount flag is up
            if (img_mounted) begin
                file_size <= img_size;
            end
        end
    end

    // Streamer gets a single-cycle start per mount
    a_start_single : assert property (
        @(posedge clk_sys) disable iff (!reset_n)
        stream_start |=> !stream_start
    );

endmodule

// ==== src/mpg_display_pkg.sv ====
package mpg_display_pkg;

    // ======================================================================
    // Video widths and types
    // ======================================================================

    // One 8-bit colour channel
    typedef logic [7:0] colour_t;

    // Raster counter width that fits an 800-pixel line
    localparam int COUNT_W = 10;

    // Byte size of a mounted image
    typedef logic [63:0] file_size_t;

    // ======================================================================
    // Default 640x480 raster
    // ======================================================================

    // Horizontal timing in pixels
    localparam int DEF_H_ACTIVE     = 640;
    localparam int DEF_H_SYNC_START = 656;
    localparam int DEF_H_SYNC_END   = 751;
    localparam int DEF_H_TOTAL      = 800;

    // Vertical timing in lines
    localparam int DEF_V_ACTIVE     = 480;
    localparam int DEF_V_SYNC_START = 490;
    localparam int DEF_V_SYNC_END   = 491;
    localparam int DEF_V_TOTAL      = 525;

    // ======================================================================
    // Control defaults
    // ======================================================================

    // Decoder vsync rising edges needed before switching over
    localparam int DEF_LOCK_EDGES = 3;

    // Heartbeat counter width whose top bit drives the user LED
    localparam int DEF_HEARTBEAT_W = 25;

    // White level for the fallback picture
    localparam colour_t FALLBACK_COLOUR = '1;

endpackage

// ==== src/mpg_display_top.sv ====
module mpg_display_top #(
    parameter int H_ACTIVE     = mpg_display_pkg::DEF_H_ACTIVE,
    parameter int H_SYNC_START = mpg_display_pkg::DEF_H_SYNC_START,
    parameter int H_SYNC_END   = mpg_display_pkg::DEF_H_SYNC_END,
    parameter int H_TOTAL      = mpg_display_pkg::DEF_H_TOTAL,
    parameter int V_ACTIVE     = mpg_display_pkg::DEF_V_ACTIVE,
    parameter int V_SYNC_START = mpg_display_pkg::DEF_V_SYNC_START,
    parameter int V_SYNC_END   = mpg_display_pkg::DEF_V_SYNC_END,
    parameter int V_TOTAL      = mpg_display_pkg::DEF_V_TOTAL,
    parameter int LOCK_EDGES   = mpg_display_pkg::DEF_LOCK_EDGES,
    parameter int HEARTBEAT_W  = mpg_display_pkg::DEF_HEARTBEAT_W
) (
    input  logic                        clk_sys,
    input  logic                        reset_n,
    // Decoder video
    input  mpg_display_pkg::colour_t    core_r,
    input  mpg_display_pkg::colour_t    core_g,
    input  mpg_display_pkg::colour_t    core_b,
    input  logic                        core_hsync,
    input  logic                        core_vsync,
    input  logic                        core_de,
    // Image mount from the host
    input  logic                        img_mounted,
    input  mpg_display_pkg::file_size_t img_size,
    // Streamer flags
    input  logic                        stream_active,
    input  logic                        stream_valid,
    // Selected video
    output mpg_display_pkg::colour_t    vga_r,
    output mpg_display_pkg::colour_t    vga_g,
    output mpg_display_pkg::colour_t    vga_b,
    output logic                        vga_hs,
    output logic                        vga_vs,
    output logic                        vga_de,
    output logic                        ce_pixel,
    // Stream control
    output logic                        stream_start,
    output mpg_display_pkg::file_size_t file_size,
    output logic                        core_video_active,
    // Board LEDs
    output logic                        led_user,
    output logic [1:0]                  led_disk
);

    // Fallback timing into the source mux
    logic fb_hs;
    logic fb_vs;
    logic fb_de;

    // ======================================================================
    // Video path
    // ======================================================================

    video_frame_timer #(
        .H_ACTIVE     (H_ACTIVE),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_END   (H_SYNC_END),
        .H_TOTAL      (H_TOTAL),
        .V_ACTIVE     (V_ACTIVE),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_END   (V_SYNC_END),
        .V_TOTAL      (V_TOTAL)
    ) u_frame_timer (
        .clk_sys  (clk_sys),
        .reset_n  (reset_n),
        .ce_pixel (ce_pixel),
        .fb_hs    (fb_hs),
        .fb_vs    (fb_vs),
        .fb_de    (fb_de)
    );

    video_source_select #(
        .LOCK_EDGES (LOCK_EDGES)
    ) u_source_select (
        .clk_sys           (clk_sys),
        .reset_n           (reset_n),
        .fb_hs             (fb_hs),
        .fb_vs             (fb_vs),
        .fb_de             (fb_de),
        .core_r            (core_r),
        .core_g            (core_g),
        .core_b            (core_b),
        .core_hsync        (core_hsync),
        .core_vsync        (core_vsync),
        .core_de           (core_de),
        .vga_r             (vga_r),
        .vga_g             (vga_g),
        .vga_b             (vga_b),
        .vga_hs            (vga_hs),
        .vga_vs            (vga_vs),
        .vga_de            (vga_de),
        .core_video_active (core_video_active)
    );

    // ======================================================================
    // Stream control and status
    // ======================================================================

    image_mount_tracker u_mount_tracker (
        .clk_sys      (clk_sys),
        .reset_n      (reset_n),
        .img_mounted  (img_mounted),
        .img_size     (img_size),
        .stream_start (stream_start),
        .file_size    (file_size)
    );

    status_led #(
        .HEARTBEAT_W (HEARTBEAT_W)
    ) u_status_led (
        .clk_sys       (clk_sys),
        .reset_n       (reset_n),
        .stream_active (stream_active),
        .stream_valid  (stream_valid),
        .led_user      (led_user),
        .led_disk      (led_disk)
    );

endmodule

// ==== src/status_led.sv ====
module status_led #(
    parameter int HEARTBEAT_W = mpg_display_pkg::DEF_HEARTBEAT_W
) (
    input  logic       clk_sys,
    input  logic       reset_n,
    input  logic       stream_active,
    input  logic       stream_valid,
    output logic       led_user,
    output logic [1:0] led_disk
);

    logic [HEARTBEAT_W-1:0] heartbeat;

    // ======================================================================
    // Heartbeat and disk activity
    // ======================================================================

    // Free-running counter giving about one blink per second at 27 MHz
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            heartbeat <= '0;
        end else begin
            heartbeat <= heartbeat + 1'b1;
        end
    end

    assign led_user = heartbeat[HEARTBEAT_W-1];

    // Upper LED shows streaming active and lower one shows data moving
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            led_disk <= 2'b00;
        end else begin
            led_disk <= {stream_active, stream_valid};
        end
    end

endmodule

// ==== src/video_frame_timer.sv ====
module video_frame_timer #(
    parameter int H_ACTIVE     = mpg_display_pkg::DEF_H_ACTIVE,
    parameter int H_SYNC_START = mpg_display_pkg::DEF_H_SYNC_START,
    parameter int H_SYNC_END   = mpg_display_pkg::DEF_H_SYNC_END,
    parameter int H_TOTAL      = mpg_display_pkg::DEF_H_TOTAL,
    parameter int V_ACTIVE     = mpg_display_pkg::DEF_V_ACTIVE,
    parameter int V_SYNC_START = mpg_display_pkg::DEF_V_SYNC_START,
    parameter int V_SYNC_END   = mpg_display_pkg::DEF_V_SYNC_END,
    parameter int V_TOTAL      = mpg_display_pkg::DEF_V_TOTAL
) (
    input  logic clk_sys,
    input  logic reset_n,
    output logic ce_pixel,
    output logic fb_hs,
    output logic fb_vs,
    output logic fb_de
);

    // Fixed clk_sys to pixel ratio
    localparam int CE_DIV = 4;
    localparam int DIV_W  = $clog2(CE_DIV);
    localparam int CW     = mpg_display_pkg::COUNT_W;

    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CE_DIV - 1);

    // Raster thresholds at counter width
    localparam logic [CW-1:0] H_LAST   = CW'(H_TOTAL - 1);
    localparam logic [CW-1:0] V_LAST   = CW'(V_TOTAL - 1);
    localparam logic [CW-1:0] H_ACT_C  = CW'(H_ACTIVE);
    localparam logic [CW-1:0] V_ACT_C  = CW'(V_ACTIVE);
    localparam logic [CW-1:0] H_SS_C   = CW'(H_SYNC_START);
    localparam logic [CW-1:0] H_SE_C   = CW'(H_SYNC_END);
    localparam logic [CW-1:0] V_SS_C   = CW'(V_SYNC_START);
    localparam logic [CW-1:0] V_SE_C   = CW'(V_SYNC_END);

    logic [DIV_W-1:0] div_cnt;
    logic [CW-1:0]    hcount;
    logic [CW-1:0]    vcount;
    logic             h_wrap;
    logic             v_wrap;

    // ======================================================================
    // Pixel enable
    // ======================================================================

    // Divider starts at zero so the first cycle after reset is a pixel
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
        end else if (div_cnt == DIV_LAST) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign ce_pixel = (div_cnt == '0);

    // ======================================================================
    // Fallback raster
    // ======================================================================

    assign h_wrap = (hcount == H_LAST);
    assign v_wrap = (vcount == V_LAST);

    // Horizontal and vertical position, stepped once per pixel
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            hcount <= '0;
            vcount <= '0;
        end else if (ce_pixel) begin
            if (h_wrap) begin
                hcount <= '0;
                // Next line only at the end of the current one
                if (v_wrap) begin
                    vcount <= '0;
                end else begin
                    vcount <= vcount + 1'b1;
                end
            end else begin
                hcount <= hcount + 1'b1;
            end
        end
    end

    // Syncs and enable decoded from the position before the step
    // Active high, same polarity as the decoder syncs
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            fb_hs <= 1'b0;
            fb_vs <= 1'b0;
            fb_de <= 1'b0;
        end else if (ce_pixel) begin
            fb_hs <= (hcount >= H_SS_C) && (hcount <= H_SE_C);
            fb_vs <= (vcount >= V_SS_C) && (vcount <= V_SE_C);
            fb_de <= (hcount < H_ACT_C) && (vcount < V_ACT_C);
        end
    end

    // Position never leaves the raster for any enable pattern
    a_raster_bounds : assert property (
        @(posedge clk_sys) disable iff (!reset_n)
        (int'(hcount) < H_TOTAL) && (int'(vcount) < V_TOTAL)
    );

endmodule

// ==== src/video_source_select.sv ====
module video_source_select #(
    parameter int LOCK_EDGES = mpg_display_pkg::DEF_LOCK_EDGES
) (
    input  logic                     clk_sys,
    input  logic                     reset_n,
    input  logic                     fb_hs,
    input  logic                     fb_vs,
    input  logic                     fb_de,
    input  mpg_display_pkg::colour_t core_r,
    input  mpg_display_pkg::colour_t core_g,
    input  mpg_display_pkg::colour_t core_b,
    input  logic                     core_hsync,
    input  logic                     core_vsync,
    input  logic                     core_de,
    output mpg_display_pkg::colour_t vga_r,
    output mpg_display_pkg::colour_t vga_g,
    output mpg_display_pkg::colour_t vga_b,
    output logic                     vga_hs,
    output logic                     vga_vs,
    output logic                     vga_de,
    output logic                     core_video_active
);

    // Edge count must hold LOCK_EDGES itself
    localparam int EDGE_W = $clog2(LOCK_EDGES + 1);

    localparam logic [EDGE_W-1:0] EDGE_LOCK = EDGE_W'(LOCK_EDGES);

    logic              vsync_prev;
    logic              vsync_rise;
    logic [EDGE_W-1:0] edge_cnt;
    logic [EDGE_W-1:0] edge_cnt_next;

    // ======================================================================
    // Decoder alive detection
    // ======================================================================

    assign vsync_rise = core_vsync && !vsync_prev;

    // Count only until the switch, then hold
    always_comb begin
        edge_cnt_next = edge_cnt;
        if (vsync_rise && !core_video_active && (edge_cnt != EDGE_LOCK)) begin
            edge_cnt_next = edge_cnt + 1'b1;
        end
    end

    // Select flag sets on the same clock that records the last edge
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            vsync_prev        <= 1'b0;
            edge_cnt          <= '0;
            core_video_active <= 1'b0;
        end else begin
            vsync_prev <= core_vsync;
            edge_cnt   <= edge_cnt_next;
            if (edge_cnt_next == EDGE_LOCK) begin
                core_video_active <= 1'b1;
            end
        end
    end

    // ======================================================================
    // Output steering
    // ======================================================================

    // White picture on fallback timing until the decoder takes over
    assign vga_r  = core_video_active ? core_r     : mpg_display_pkg::FALLBACK_COLOUR;
    assign vga_g  = core_video_active ? core_g     : mpg_display_pkg::FALLBACK_COLOUR;
    assign vga_b  = core_video_active ? core_b     : mpg_display_pkg::FALLBACK_COLOUR;
    assign vga_hs = core_video_active ? core_hsync : fb_hs;
    assign vga_vs = core_video_active ? core_vsync : fb_vs;
    assign vga_de = core_video_active ? core_de    : fb_de;

    // Once on the decoder picture, no return to fallback short of reset
    a_select_sticky : assert property (
        @(posedge clk_sys) disable iff (!reset_n)
        core_video_active |=> core_video_active
    );

endmodule
